/* rob_pkg.sv */
`default_nettype none

package rob_pkg;

  // machine width and buffer sizing
  localparam int num_super = 2;
  localparam int num_rob = 16;
  localparam int rob_idx_w = 4;

  // register space
  localparam int num_arch = 16;
  localparam int num_phys = 32;
  localparam int tag_w = 5;
  localparam int arch_w = 4;

  // opcodes, anything else decodes as illegal
  localparam logic [3:0] op_add = 4'h1;
  localparam logic [3:0] op_addi = 4'h2;
  localparam logic [3:0] op_mul = 4'h3;
  localparam logic [3:0] op_br = 4'h4;
  localparam logic [3:0] op_halt = 4'h5;

  // mul is the slowest op
  localparam int max_lat = 3;

  // one 16-bit instruction word, two field layouts
  typedef union packed {
    // alu and mul format
    struct packed {
      logic [3:0] opcode;
      logic [arch_w-1:0] dest;
      logic [arch_w-1:0] src_a;
      logic [arch_w-1:0] src_b;
    } reg_view;
    // branch format, mispredict outcome carried in the word
    struct packed {
      logic [3:0] opcode;
      logic mispredict;
      logic [10:0] offset;
    } br_view;
  } inst_word_u;

endpackage

`default_nettype wire

/* inst_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_decode (
  input wire rob_pkg::inst_word_u [rob_pkg::num_super-1:0] inst_word,
  output logic [rob_pkg::num_super-1:0] dec_has_dest,
  output logic [rob_pkg::num_super-1:0][rob_pkg::arch_w-1:0] dec_dest,
  output logic [rob_pkg::num_super-1:0][$clog2(rob_pkg::max_lat+1)-1:0] dec_lat,
  output logic [rob_pkg::num_super-1:0] dec_branch,
  output logic [rob_pkg::num_super-1:0] dec_mispredict,
  output logic [rob_pkg::num_super-1:0] dec_halt,
  output logic [rob_pkg::num_super-1:0] dec_illegal
);

  always_comb begin
    for (int i = 0; i < rob_pkg::num_super; i++) begin
      // defaults describe a single-cycle op with no side effects
      dec_has_dest[i] = 1'b0;
      dec_dest[i] = inst_word[i].reg_view.dest;
      dec_lat[i] = 2'd1;
      dec_branch[i] = 1'b0;
      dec_mispredict[i] = 1'b0;
      dec_halt[i] = 1'b0;
      dec_illegal[i] = 1'b0;

      case (inst_word[i].reg_view.opcode)
        rob_pkg::op_add, rob_pkg::op_addi: begin
          dec_has_dest[i] = 1'b1;
        end
        rob_pkg::op_mul: begin
          dec_has_dest[i] = 1'b1;
          dec_lat[i] = 2'd3;
        end
        rob_pkg::op_br: begin
          // outcome bit only exists in the branch layout
          dec_branch[i] = 1'b1;
          dec_mispredict[i] = inst_word[i].br_view.mispredict;
        end
        rob_pkg::op_halt: begin
          dec_halt[i] = 1'b1;
        end
        default: begin
          dec_illegal[i] = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* reg_rename.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_rename (
  input wire clock,
  input wire reset,
  input wire dispatch,
  input wire [rob_pkg::num_super-1:0] dec_has_dest,
  input wire [rob_pkg::num_super-1:0][rob_pkg::arch_w-1:0] dec_dest,
  output logic [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] new_tag,
  output logic [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] old_tag,
  input wire [rob_pkg::num_super-1:0] retire_en,
  input wire [rob_pkg::num_super-1:0] retire_has_dest,
  input wire [rob_pkg::num_super-1:0][rob_pkg::arch_w-1:0] retire_dest,
  input wire [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] retire_tag,
  input wire [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] retire_old_tag,
  input wire recover_done
);

  // speculative and committed maps
  logic [rob_pkg::tag_w-1:0] map_table [rob_pkg::num_arch];
  logic [rob_pkg::tag_w-1:0] arch_map [rob_pkg::num_arch];

  // circular free list, one slot per physical tag
  logic [rob_pkg::tag_w-1:0] free_list [rob_pkg::num_phys];
  logic [rob_pkg::tag_w-1:0] fl_head;
  logic [rob_pkg::tag_w-1:0] fl_tail;
  // where head would sit if every retired op were the last dispatched
  logic [rob_pkg::tag_w-1:0] fl_ret;

  logic [rob_pkg::num_super-1:0] ret_free;

  always_comb begin
    // slot 1 only skips a list entry when slot 0 consumed one
    new_tag[0] = free_list[fl_head];
    new_tag[1] = free_list[fl_head + dec_has_dest[0]];

    // same-pair dependency on slot 0's destination
    old_tag[0] = map_table[dec_dest[0]];
    if (dec_has_dest[0] && dec_dest[0] == dec_dest[1]) begin
      old_tag[1] = new_tag[0];
    end else begin
      old_tag[1] = map_table[dec_dest[1]];
    end

    ret_free = retire_en & retire_has_dest;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < rob_pkg::num_arch; r++) begin
        map_table[r] <= rob_pkg::tag_w'(r);
        arch_map[r] <= rob_pkg::tag_w'(r);
      end
      // tags above the architectural range start out free
      for (int s = 0; s < rob_pkg::num_phys; s++) begin
        free_list[s] <= rob_pkg::tag_w'(s + rob_pkg::num_arch);
      end
      fl_head <= '0;
      fl_ret <= '0;
      fl_tail <= rob_pkg::tag_w'(rob_pkg::num_arch);
    end else begin
      if (dispatch) begin
        for (int s = 0; s < rob_pkg::num_super; s++) begin
          if (dec_has_dest[s]) begin
            map_table[dec_dest[s]] <= new_tag[s];
          end
        end
        fl_head <= fl_head + dec_has_dest[0] + dec_has_dest[1];
      end

      // commit new mappings, recycle the displaced tags
      for (int s = 0; s < rob_pkg::num_super; s++) begin
        if (ret_free[s]) begin
          arch_map[retire_dest[s]] <= retire_tag[s];
        end
      end
      if (ret_free[0]) begin
        free_list[fl_tail] <= retire_old_tag[0];
      end
      if (ret_free[1]) begin
        free_list[fl_tail + ret_free[0]] <= retire_old_tag[1];
      end
      fl_tail <= fl_tail + ret_free[0] + ret_free[1];
      fl_ret <= fl_ret + ret_free[0] + ret_free[1];

      // squashed allocations return by rewinding head
      if (recover_done) begin
        for (int r = 0; r < rob_pkg::num_arch; r++) begin
          map_table[r] <= arch_map[r];
        end
        fl_head <= fl_ret;
      end
    end
  end

endmodule

`default_nettype wire

/* exec_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_pipe (
  input wire clock,
  input wire reset,
  input wire issue,
  input wire [rob_pkg::num_super-1:0][rob_pkg::rob_idx_w-1:0] disp_idx,
  input wire [rob_pkg::num_super-1:0][$clog2(rob_pkg::max_lat+1)-1:0] dec_lat,
  input wire [rob_pkg::num_super-1:0] dec_branch,
  input wire [rob_pkg::num_super-1:0] dec_mispredict,
  input wire [rob_pkg::num_super-1:0] dec_halt,
  input wire [rob_pkg::num_super-1:0] dec_illegal,
  output logic [rob_pkg::num_super-1:0] complete_en,
  output logic [rob_pkg::num_super-1:0][rob_pkg::rob_idx_w-1:0] complete_idx,
  output logic rollback_en,
  output logic [rob_pkg::rob_idx_w-1:0] rollback_idx,
  output logic exec_busy
);

  // stage 0 completes, stage k has k cycles left
  logic [rob_pkg::num_super-1:0][rob_pkg::max_lat-1:0] stage_valid;
  logic [rob_pkg::num_super-1:0][rob_pkg::max_lat-1:0][rob_pkg::rob_idx_w-1:0] stage_idx;
  logic [rob_pkg::num_super-1:0][rob_pkg::max_lat-1:0] stage_mis;

  logic [rob_pkg::num_super-1:0][rob_pkg::max_lat-1:0] shifted_valid;
  logic [rob_pkg::num_super-1:0][rob_pkg::max_lat-1:0] entry_sel;
  logic [rob_pkg::num_super-1:0] lane_issue;
  logic [rob_pkg::num_super-1:0] lane_mis;
  logic [rob_pkg::num_super-1:0] placed;

  always_comb begin
    for (int i = 0; i < rob_pkg::num_super; i++) begin
      // halt and illegal were written complete, nothing to run
      lane_issue[i] = issue & ~dec_halt[i] & ~dec_illegal[i];
      lane_mis[i] = dec_branch[i] & dec_mispredict[i];
      shifted_valid[i] = stage_valid[i] >> 1;
      entry_sel[i] = '0;
      placed[i] = 1'b0;
      // an older slow op may already own the target stage, then the
      // new op takes the next free one and finishes a cycle later
      for (int s = 0; s < rob_pkg::max_lat; s++) begin
        if (lane_issue[i] && !placed[i] && s + 1 >= dec_lat[i] && !shifted_valid[i][s]) begin
          entry_sel[i][s] = 1'b1;
          placed[i] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_valid <= '0;
    end else begin
      stage_valid <= shifted_valid | entry_sel;
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < rob_pkg::num_super; i++) begin
      for (int s = 0; s < rob_pkg::max_lat; s++) begin
        if (entry_sel[i][s]) begin
          stage_idx[i][s] <= disp_idx[i];
          stage_mis[i][s] <= lane_mis[i];
        end else if (s < rob_pkg::max_lat - 1) begin
          stage_idx[i][s] <= stage_idx[i][s+1];
          stage_mis[i][s] <= stage_mis[i][s+1];
        end
      end
    end
  end

  always_comb begin
    rollback_en = 1'b0;
    rollback_idx = stage_idx[0][0];
    // walk down so lane 0 has the last word
    for (int i = rob_pkg::num_super - 1; i >= 0; i--) begin
      complete_en[i] = stage_valid[i][0];
      complete_idx[i] = stage_idx[i][0];
      if (stage_valid[i][0] && stage_mis[i][0]) begin
        rollback_en = 1'b1;
        rollback_idx = stage_idx[i][0];
      end
    end
    exec_busy = |stage_valid;
  end

endmodule

`default_nettype wire

/* rob_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_core (
  input wire clock,
  input wire reset,
  input wire inst_valid,
  input wire [rob_pkg::num_super-1:0] dec_has_dest,
  input wire [rob_pkg::num_super-1:0][rob_pkg::arch_w-1:0] dec_dest,
  input wire [rob_pkg::num_super-1:0] dec_halt,
  input wire [rob_pkg::num_super-1:0] dec_illegal,
  input wire [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] new_tag,
  input wire [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] old_tag,
  input wire [rob_pkg::num_super-1:0] complete_en,
  input wire [rob_pkg::num_super-1:0][rob_pkg::rob_idx_w-1:0] complete_idx,
  input wire rollback_en,
  input wire [rob_pkg::rob_idx_w-1:0] rollback_idx,
  input wire exec_busy,
  output logic dispatch_ready,
  output logic dispatch,
  output logic [rob_pkg::num_super-1:0][rob_pkg::rob_idx_w-1:0] disp_idx,
  output logic [rob_pkg::num_super-1:0] retire_en,
  output logic [rob_pkg::num_super-1:0] retire_has_dest,
  output logic [rob_pkg::num_super-1:0][rob_pkg::arch_w-1:0] retire_dest,
  output logic [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] retire_tag,
  output logic [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] retire_old_tag,
  output logic halt,
  output logic illegal,
  output logic recovering,
  output logic recover_done
);

  // entry state
  logic [rob_pkg::num_rob-1:0] entry_valid;
  logic [rob_pkg::num_rob-1:0] entry_complete;
  logic [rob_pkg::num_rob-1:0] entry_has_dest;
  logic [rob_pkg::num_rob-1:0] entry_halt;
  logic [rob_pkg::num_rob-1:0] entry_illegal;
  logic [rob_pkg::arch_w-1:0] entry_dest [rob_pkg::num_rob];
  logic [rob_pkg::tag_w-1:0] entry_tag [rob_pkg::num_rob];
  logic [rob_pkg::tag_w-1:0] entry_old_tag [rob_pkg::num_rob];

  logic [rob_pkg::rob_idx_w-1:0] head;
  logic [rob_pkg::rob_idx_w-1:0] tail;
  logic [rob_pkg::rob_idx_w-1:0] head_plus_one;
  logic [rob_pkg::num_super-1:0][rob_pkg::rob_idx_w-1:0] retire_idx;
  logic [rob_pkg::num_super-1:0] slot_free;

  // rollback squash
  logic rollback_ok;
  logic [rob_pkg::rob_idx_w-1:0] rb_age;
  logic [rob_pkg::rob_idx_w-1:0] entry_age;
  logic [rob_pkg::num_rob-1:0] squash;

  assign head_plus_one = head + 1'b1;
  assign rollback_ok = rollback_en & entry_valid[rollback_idx];
  assign recover_done = recovering & ~|entry_valid & ~exec_busy;

  always_comb begin
    retire_idx[0] = head;
    retire_idx[1] = head_plus_one;
    retire_en[0] = entry_valid[head] & entry_complete[head];
    retire_en[1] = entry_valid[head_plus_one] & entry_complete[head_plus_one] & retire_en[0];
    halt = 1'b0;
    illegal = 1'b0;
    for (int s = 0; s < rob_pkg::num_super; s++) begin
      retire_has_dest[s] = entry_has_dest[retire_idx[s]];
      retire_dest[s] = entry_dest[retire_idx[s]];
      retire_tag[s] = entry_tag[retire_idx[s]];
      retire_old_tag[s] = entry_old_tag[retire_idx[s]];
      halt = halt | (retire_en[s] & entry_halt[retire_idx[s]]);
      illegal = illegal | (retire_en[s] & entry_illegal[retire_idx[s]]);
    end
  end

  always_comb begin
    // a slot is usable if empty or leaving at this edge
    for (int s = 0; s < rob_pkg::num_super; s++) begin
      disp_idx[s] = tail + s[rob_pkg::rob_idx_w-1:0];
      slot_free[s] = ~entry_valid[disp_idx[s]]
                   | (disp_idx[s] == head & retire_en[0])
                   | (disp_idx[s] == head_plus_one & retire_en[1]);
    end
    dispatch_ready = ~recovering & ~rollback_en & (&slot_free);
    dispatch = inst_valid & dispatch_ready;
  end

  // age relative to head decides who is younger than the branch
  always_comb begin
    rb_age = rollback_idx - head;
    for (int i = 0; i < rob_pkg::num_rob; i++) begin
      entry_age = i[rob_pkg::rob_idx_w-1:0] - head;
      squash[i] = rollback_ok & (entry_age > rb_age);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
      entry_complete <= '0;
      head <= '0;
      tail <= '0;
      recovering <= 1'b0;
    end else begin
      // late results for squashed entries fall through here
      for (int s = 0; s < rob_pkg::num_super; s++) begin
        if (complete_en[s] && entry_valid[complete_idx[s]]) begin
          entry_complete[complete_idx[s]] <= 1'b1;
        end
        if (retire_en[s]) begin
          entry_valid[retire_idx[s]] <= 1'b0;
        end
      end
      if (dispatch) begin
        for (int s = 0; s < rob_pkg::num_super; s++) begin
          entry_valid[disp_idx[s]] <= 1'b1;
          entry_complete[disp_idx[s]] <= dec_halt[s] | dec_illegal[s];
        end
      end
      for (int i = 0; i < rob_pkg::num_rob; i++) begin
        if (squash[i]) begin
          entry_valid[i] <= 1'b0;
        end
      end

      head <= head + retire_en[0] + retire_en[1];
      if (rollback_ok) begin
        tail <= rollback_idx + 1'b1;
      end else if (dispatch) begin
        tail <= disp_idx[1] + 1'b1;
      end

      // recovery holds off dispatch until the machine is empty
      if (recover_done) begin
        recovering <= 1'b0;
      end else if (rollback_ok) begin
        recovering <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch) begin
      for (int s = 0; s < rob_pkg::num_super; s++) begin
        entry_has_dest[disp_idx[s]] <= dec_has_dest[s];
        entry_dest[disp_idx[s]] <= dec_dest[s];
        entry_tag[disp_idx[s]] <= new_tag[s];
        entry_old_tag[disp_idx[s]] <= old_tag[s];
        entry_halt[disp_idx[s]] <= dec_halt[s];
        entry_illegal[disp_idx[s]] <= dec_illegal[s];
      end
    end
  end

endmodule

`default_nettype wire

/* ooo_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ooo_top (
  input wire clock,
  input wire reset,
  input wire inst_valid,
  input wire rob_pkg::inst_word_u [rob_pkg::num_super-1:0] inst_word,
  output logic dispatch_ready,
  output logic [rob_pkg::num_super-1:0] retire_en,
  output logic [rob_pkg::num_super-1:0][rob_pkg::arch_w-1:0] retire_dest,
  output logic [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] retire_tag,
  output logic halt,
  output logic illegal,
  output logic recovering
);

  // decode results
  logic [rob_pkg::num_super-1:0] dec_has_dest;
  logic [rob_pkg::num_super-1:0][rob_pkg::arch_w-1:0] dec_dest;
  logic [rob_pkg::num_super-1:0][$clog2(rob_pkg::max_lat+1)-1:0] dec_lat;
  logic [rob_pkg::num_super-1:0] dec_branch;
  logic [rob_pkg::num_super-1:0] dec_mispredict;
  logic [rob_pkg::num_super-1:0] dec_halt;
  logic [rob_pkg::num_super-1:0] dec_illegal;

  // rename
  logic [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] new_tag;
  logic [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] old_tag;

  // execute and buffer handshake
  logic dispatch;
  logic [rob_pkg::num_super-1:0][rob_pkg::rob_idx_w-1:0] disp_idx;
  logic [rob_pkg::num_super-1:0] complete_en;
  logic [rob_pkg::num_super-1:0][rob_pkg::rob_idx_w-1:0] complete_idx;
  logic rollback_en;
  logic [rob_pkg::rob_idx_w-1:0] rollback_idx;
  logic exec_busy;

  // retirement back to rename
  logic [rob_pkg::num_super-1:0] retire_has_dest;
  logic [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] retire_old_tag;
  logic recover_done;

  inst_decode u_decode (
    .inst_word(inst_word), .dec_has_dest(dec_has_dest), .dec_dest(dec_dest),
    .dec_lat(dec_lat), .dec_branch(dec_branch), .dec_mispredict(dec_mispredict),
    .dec_halt(dec_halt), .dec_illegal(dec_illegal)
  );

  reg_rename u_rename (
    .clock(clock), .reset(reset), .dispatch(dispatch),
    .dec_has_dest(dec_has_dest), .dec_dest(dec_dest),
    .new_tag(new_tag), .old_tag(old_tag),
    .retire_en(retire_en), .retire_has_dest(retire_has_dest), .retire_dest(retire_dest),
    .retire_tag(retire_tag), .retire_old_tag(retire_old_tag), .recover_done(recover_done)
  );

  exec_pipe u_exec (
    .clock(clock), .reset(reset), .issue(dispatch), .disp_idx(disp_idx),
    .dec_lat(dec_lat), .dec_branch(dec_branch), .dec_mispredict(dec_mispredict),
    .dec_halt(dec_halt), .dec_illegal(dec_illegal),
    .complete_en(complete_en), .complete_idx(complete_idx),
    .rollback_en(rollback_en), .rollback_idx(rollback_idx), .exec_busy(exec_busy)
  );

  rob_core u_rob (
    .clock(clock), .reset(reset), .inst_valid(inst_valid),
    .dec_has_dest(dec_has_dest), .dec_dest(dec_dest), .dec_halt(dec_halt),
    .dec_illegal(dec_illegal), .new_tag(new_tag), .old_tag(old_tag),
    .complete_en(complete_en), .complete_idx(complete_idx),
    .rollback_en(rollback_en), .rollback_idx(rollback_idx), .exec_busy(exec_busy),
    .dispatch_ready(dispatch_ready), .dispatch(dispatch), .disp_idx(disp_idx),
    .retire_en(retire_en), .retire_has_dest(retire_has_dest), .retire_dest(retire_dest),
    .retire_tag(retire_tag), .retire_old_tag(retire_old_tag),
    .halt(halt), .illegal(illegal), .recovering(recovering), .recover_done(recover_done)
  );

endmodule

`default_nettype wire

/* rob_props.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_props (
  input wire clock,
  input wire reset,
  input wire [rob_pkg::num_super-1:0] retire_en,
  input wire recovering,
  input wire [rob_pkg::num_rob-1:0] entry_valid,
  input wire [rob_pkg::rob_idx_w-1:0] head,
  input wire [rob_pkg::rob_idx_w-1:0] tail
);

  int fail_count = 0;

  // second slot never reaches past the youngest entry
  retire_order: assert property (@(posedge clock) disable iff (reset)
    retire_en[1] |-> (head + 1'b1) != tail)
    else begin
      fail_count++;
      $error("second retire slot points past the tail");
    end

  // nothing new enters the buffer for the whole recovery
  no_dispatch_recovering: assert property (@(posedge clock) disable iff (reset)
    recovering |=> (entry_valid & ~$past(entry_valid)) == '0)
    else begin
      fail_count++;
      $error("entry allocated during recovery");
    end

  // valid entries form one run starting at head
  head_valid: assert property (@(posedge clock) disable iff (reset)
    !entry_valid[head] |-> entry_valid == '0)
    else begin
      fail_count++;
      $error("valid entry behind an empty head");
    end

endmodule

bind rob_core rob_props props (
  .clock(clock), .reset(reset), .retire_en(retire_en), .recovering(recovering),
  .entry_valid(entry_valid), .head(head), .tail(tail)
);

`default_nettype wire

/* rob_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rob_tb;

  // pairs offered by all tests together, sizes the watchdog
  localparam int total_pairs = 4 + 12 + 7 + 20 + 2;
  localparam int watchdog_cycles = total_pairs * 40;

  typedef struct packed {
    logic [rob_pkg::arch_w-1:0] dest;
    logic has_dest;
    logic [rob_pkg::tag_w-1:0] tag;
    logic [rob_pkg::tag_w-1:0] old_tag;
    logic halt;
    logic illegal;
  } exp_entry_t;

  logic clock;
  logic reset;
  logic inst_valid;
  rob_pkg::inst_word_u [rob_pkg::num_super-1:0] inst_word;
  logic dispatch_ready;
  logic [rob_pkg::num_super-1:0] retire_en;
  logic [rob_pkg::num_super-1:0][rob_pkg::arch_w-1:0] retire_dest;
  logic [rob_pkg::num_super-1:0][rob_pkg::tag_w-1:0] retire_tag;
  logic halt;
  logic illegal;
  logic recovering;

  // reference model state
  exp_entry_t exp_q [$];
  logic [rob_pkg::tag_w-1:0] map_m [rob_pkg::num_arch];
  logic [rob_pkg::tag_w-1:0] arch_m [rob_pkg::num_arch];
  logic [rob_pkg::tag_w-1:0] fl_m [rob_pkg::num_phys];
  logic [rob_pkg::tag_w-1:0] fl_head_m;
  logic [rob_pkg::tag_w-1:0] fl_tail_m;
  logic [rob_pkg::tag_w-1:0] fl_ret_m;
  logic squash_pending;
  logic [31:0] lfsr_state;
  int error_count;
  int halt_seen;
  int illegal_seen;
  int rollback_count;

  ooo_top dut (
    .clock(clock), .reset(reset), .inst_valid(inst_valid), .inst_word(inst_word),
    .dispatch_ready(dispatch_ready), .retire_en(retire_en), .retire_dest(retire_dest),
    .retire_tag(retire_tag), .halt(halt), .illegal(illegal), .recovering(recovering)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic stop_with_error(input string line);
    error_count++;
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_error($sformatf("FAILED %s: got %h expected %h", name, actual, expected));
    end
  endtask

  // taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [3:0] lfsr_bits(input int count);
    logic [3:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[2:0], lfsr_bit()};
    end
    return value;
  endfunction

  function automatic rob_pkg::inst_word_u reg_word(input logic [3:0] op,
                                                   input logic [3:0] dest);
    rob_pkg::inst_word_u w;
    w.reg_view.opcode = op;
    w.reg_view.dest = dest;
    w.reg_view.src_a = dest + 4'd1;
    w.reg_view.src_b = 4'h0;
    return w;
  endfunction

  function automatic rob_pkg::inst_word_u branch_word(input logic mispredict);
    rob_pkg::inst_word_u w;
    w.br_view.opcode = rob_pkg::op_br;
    w.br_view.mispredict = mispredict;
    w.br_view.offset = 11'h05a;
    return w;
  endfunction

  // identity map, tags 16 to 31 free
  task automatic model_reset();
    for (int r = 0; r < rob_pkg::num_arch; r++) begin
      map_m[r] = rob_pkg::tag_w'(r);
      arch_m[r] = rob_pkg::tag_w'(r);
    end
    for (int s = 0; s < rob_pkg::num_phys; s++) begin
      fl_m[s] = rob_pkg::tag_w'(s + rob_pkg::num_arch);
    end
    fl_head_m = '0;
    fl_ret_m = '0;
    fl_tail_m = rob_pkg::tag_w'(rob_pkg::num_arch);
    squash_pending = 1'b0;
  endtask

  task automatic model_dispatch(input rob_pkg::inst_word_u w0, input rob_pkg::inst_word_u w1);
    rob_pkg::inst_word_u w;
    exp_entry_t e;
    logic [3:0] op;
    for (int s = 0; s < rob_pkg::num_super; s++) begin
      w = (s == 0) ? w0 : w1;
      op = w.reg_view.opcode;
      if (!squash_pending) begin
        e.dest = w.reg_view.dest;
        e.has_dest = (op == rob_pkg::op_add) || (op == rob_pkg::op_addi)
                   || (op == rob_pkg::op_mul);
        e.halt = (op == rob_pkg::op_halt);
        e.illegal = !(e.has_dest || e.halt || op == rob_pkg::op_br);
        e.tag = '0;
        e.old_tag = '0;
        if (e.has_dest) begin
          e.tag = fl_m[fl_head_m];
          e.old_tag = map_m[e.dest];
          map_m[e.dest] = e.tag;
          fl_head_m = fl_head_m + 1'b1;
        end
        exp_q.push_back(e);
        // younger work is squashed until recovery ends
        if (op == rob_pkg::op_br && w.br_view.mispredict) begin
          squash_pending = 1'b1;
        end
      end
    end
  endtask

  task automatic send_pair(input rob_pkg::inst_word_u w0, input rob_pkg::inst_word_u w1);
    while (!dispatch_ready) begin
      @(negedge clock);
    end
    inst_word[0] = w0;
    inst_word[1] = w1;
    inst_valid = 1'b1;
    model_dispatch(w0, w1);
    @(negedge clock);
    inst_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || recovering) begin
      @(negedge clock);
    end
    @(negedge clock);
  endtask

  // retirement monitor, pops the model in program order
  always @(posedge clock) begin : retire_monitor
    exp_entry_t e;
    logic exp_halt;
    logic exp_illegal;
    if (!reset) begin
      exp_halt = 1'b0;
      exp_illegal = 1'b0;
      if (retire_en[1]) begin
        check_value("retire_en[0]", retire_en[0], 1);
      end
      for (int s = 0; s < rob_pkg::num_super; s++) begin
        if (retire_en[s]) begin
          if (exp_q.size() == 0) begin
            stop_with_error("an instruction retired while none was outstanding");
          end
          e = exp_q.pop_front();
          check_value($sformatf("retire_dest[%0d]", s), retire_dest[s], e.dest);
          if (e.has_dest) begin
            check_value($sformatf("retire_tag[%0d]", s), retire_tag[s], e.tag);
            arch_m[e.dest] = e.tag;
            fl_m[fl_tail_m] = e.old_tag;
            fl_tail_m = fl_tail_m + 1'b1;
            fl_ret_m = fl_ret_m + 1'b1;
          end
          exp_halt = exp_halt | e.halt;
          exp_illegal = exp_illegal | e.illegal;
        end
      end
      check_value("halt", halt, exp_halt);
      check_value("illegal", illegal, exp_illegal);
      halt_seen += halt;
      illegal_seen += illegal;
      if (exp_q.size() > rob_pkg::num_rob) begin
        stop_with_error("more instructions outstanding than the buffer can hold");
      end
    end
  end

  // failures of the bound reorder buffer assertions
  always @(posedge clock) begin
    if (dut.u_rob.props.fail_count != 0) begin
      stop_with_error("an assertion on the reorder buffer failed");
    end
  end

  // recovery end, the renamer rewinds at this edge
  always @(negedge recovering) begin
    if (!reset) begin
      for (int r = 0; r < rob_pkg::num_arch; r++) begin
        map_m[r] = arch_m[r];
      end
      fl_head_m = fl_ret_m;
      squash_pending = 1'b0;
    end
  end

  always @(posedge recovering) begin
    rollback_count++;
  end

  task automatic check_reset_state();
    check_value("dispatch_ready", dispatch_ready, 1);
    check_value("retire_en", retire_en, 0);
    check_value("halt", halt, 0);
    check_value("illegal", illegal, 0);
    check_value("recovering", recovering, 0);
  endtask

  // slow mul ahead of a fast add in every pair
  task automatic mixed_latency_order();
    for (int p = 0; p < 4; p++) begin
      send_pair(reg_word(rob_pkg::op_mul, 4'(p)), reg_word(rob_pkg::op_add, 4'(p + 8)));
    end
    wait_drain();
  endtask

  // enough allocations to wrap into recycled tags
  task automatic rename_tag_reuse();
    for (int p = 0; p < 12; p++) begin
      if (p == 0) begin
        send_pair(reg_word(rob_pkg::op_add, 4'd7), reg_word(rob_pkg::op_addi, 4'd7));
      end else begin
        send_pair(reg_word(rob_pkg::op_addi, 4'(p)), reg_word(rob_pkg::op_add, 4'(p * 7)));
      end
    end
    wait_drain();
  endtask

  task automatic mispredict_recovery();
    int rollbacks_before;
    rollbacks_before = rollback_count;
    // muls fill lane stages so the branch resolves late
    send_pair(reg_word(rob_pkg::op_mul, 4'd1), reg_word(rob_pkg::op_mul, 4'd2));
    send_pair(reg_word(rob_pkg::op_mul, 4'd3), reg_word(rob_pkg::op_mul, 4'd4));
    send_pair(branch_word(1'b1), reg_word(rob_pkg::op_add, 4'd5));
    send_pair(reg_word(rob_pkg::op_add, 4'd14), reg_word(rob_pkg::op_add, 4'd15));
    send_pair(reg_word(rob_pkg::op_addi, 4'd13), reg_word(rob_pkg::op_add, 4'd12));
    wait_drain();
    check_value("rollback count", rollback_count, rollbacks_before + 1);
    check_value("recovering", recovering, 0);
    send_pair(reg_word(rob_pkg::op_add, 4'd5), reg_word(rob_pkg::op_add, 4'd6));
    send_pair(reg_word(rob_pkg::op_mul, 4'd1), reg_word(rob_pkg::op_addi, 4'd2));
    wait_drain();
  endtask

  task automatic random_backpressure();
    rob_pkg::inst_word_u w [rob_pkg::num_super];
    logic [1:0] pick;
    logic [3:0] op;
    for (int p = 0; p < 20; p++) begin
      for (int s = 0; s < rob_pkg::num_super; s++) begin
        pick = lfsr_bits(2);
        op = (pick == 2'd0) ? rob_pkg::op_add :
             (pick == 2'd1) ? rob_pkg::op_addi : rob_pkg::op_mul;
        w[s] = reg_word(op, lfsr_bits(4));
      end
      send_pair(w[0], w[1]);
    end
    wait_drain();
  endtask

  task automatic halt_and_illegal();
    int halts_before;
    int illegals_before;
    halts_before = halt_seen;
    illegals_before = illegal_seen;
    send_pair(reg_word(4'hf, 4'd2), reg_word(rob_pkg::op_add, 4'd3));
    // halt waits behind the mul
    send_pair(reg_word(rob_pkg::op_mul, 4'd4), reg_word(rob_pkg::op_halt, 4'd0));
    wait_drain();
    check_value("illegal count", illegal_seen, illegals_before + 1);
    check_value("halt count", halt_seen, halts_before + 1);
  endtask

  initial begin
    #(watchdog_cycles * 10);
    stop_with_error("the run took too long, a test never finished");
  end

  initial begin
    reset = 1'b1;
    inst_valid = 1'b0;
    inst_word = '0;
    error_count = 0;
    halt_seen = 0;
    illegal_seen = 0;
    rollback_count = 0;
    lfsr_state = 32'h0db7cd08;
    model_reset();
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_reset_state();
    mixed_latency_order();
    rename_tag_reuse();
    mispredict_recovery();
    random_backpressure();
    halt_and_illegal();
    if (error_count == 0 && dut.u_rob.props.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rob_pkg.sv
inst_decode.sv
reg_rename.sv
exec_pipe.sv
rob_core.sv
ooo_top.sv
rob_props.sv
rob_tb.sv
